// File: source/debug_cfg.svh
`ifndef DEBUG_CFG_SVH
`define DEBUG_CFG_SVH

// ---------------------------------------------------------------------------
// Debug display sizing
// ---------------------------------------------------------------------------

// Width of one measurement byte
`define DBG_MEAS_W 8

// Rendered views, one hex and one decimal per measurement
`define DBG_VIEWS 8

// Shift steps of one binary to BCD conversion, one per input bit
`define DBG_BCD_CYCLES 8

`endif

// File: source/seg_pkg.sv
`default_nettype none

package seg_pkg;

   // Active low digit, bit 7 is the decimal point, bits 6..0 are g..a
   typedef logic [7:0] glyph_t;

   localparam glyph_t GLYPH_DASH = 8'hBF;   // Segment g only

   // -------------------------------------------------------------------------
   // Hex digit to glyph, decimal point off
   // -------------------------------------------------------------------------
   function automatic glyph_t hex_glyph(input logic [3:0] digit);
      glyph_t g;
      case (digit)
         4'h0: g = 8'hC0;
         4'h1: g = 8'hF9;
         4'h2: g = 8'hA4;
         4'h3: g = 8'hB0;
         4'h4: g = 8'h99;
         4'h5: g = 8'h92;
         4'h6: g = 8'h82;
         4'h7: g = 8'hF8;
         4'h8: g = 8'h80;
         4'h9: g = 8'h90;
         4'hA: g = 8'h88;
         4'hB: g = 8'h83;   // Lower case b
         4'hC: g = 8'hC6;
         4'hD: g = 8'hA1;   // Lower case d
         4'hE: g = 8'h86;
         default: g = 8'h8E;
      endcase
      return g;
   endfunction

endpackage

`default_nettype wire

// File: source/meas_pkg.sv
`default_nettype none

`include "debug_cfg.svh"

package meas_pkg;

   // One hot view select, one bit per rendered view
   typedef logic [`DBG_VIEWS-1:0] view_sel_t;

   // -------------------------------------------------------------------------
   // View codes
   // -------------------------------------------------------------------------
   localparam view_sel_t VIEW_PHI_HEX   = 8'b0000_0001;
   localparam view_sel_t VIEW_DELTA_HEX = 8'b0000_0010;
   localparam view_sel_t VIEW_VBAT_HEX  = 8'b0000_0100;
   localparam view_sel_t VIEW_IBAT_HEX  = 8'b0000_1000;
   localparam view_sel_t VIEW_VBAT_DEC  = 8'b0001_0000;   // Refreshed on sample
   localparam view_sel_t VIEW_IBAT_DEC  = 8'b0010_0000;
   localparam view_sel_t VIEW_PHI_DEC   = 8'b0100_0000;
   localparam view_sel_t VIEW_DELTA_DEC = 8'b1000_0000;

endpackage

`default_nettype wire

// File: source/bin_to_bcd.sv
`timescale 1ns/100ps
`default_nettype none

`include "debug_cfg.svh"

module bin_to_bcd (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   sample,
   input  logic [`DBG_MEAS_W-1:0] bin,
   output logic                   busy,
   output logic                   done,
   output logic [3:0]             ones,
   output logic [3:0]             tens,
   output logic [3:0]             hundreds
);

   localparam int SR_W  = 12 + `DBG_MEAS_W;                // Three BCD digits over the input
   localparam int CNT_W = $clog2(`DBG_BCD_CYCLES + 1);

   logic [SR_W-1:0]  sr;
   logic [CNT_W-1:0] cnt;

   // One double dabble step: add three to digits of five or more, then shift
   function automatic logic [SR_W-1:0] dd_step(input logic [SR_W-1:0] s);
      logic [SR_W-1:0] t;
      t = s;
      for (int k = 0; k < 3; k++) begin
         if (t[`DBG_MEAS_W+4*k +: 4] >= 4'd5) begin
            t[`DBG_MEAS_W+4*k +: 4] = t[`DBG_MEAS_W+4*k +: 4] + 4'd3;
         end
      end
      return t << 1;
   endfunction

   // ------------------------------------------------------------------------
   // Conversion control
   // ------------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         busy     <= 1'b0;
         done     <= 1'b0;
         cnt      <= '0;
         ones     <= 4'd0;
         tens     <= 4'd0;
         hundreds <= 4'd0;
      end else begin
         done <= 1'b0;                                     // Single cycle pulse
         if (!busy) begin
            if (sample) begin                              // Samples while busy are dropped
               busy <= 1'b1;
               cnt  <= '0;
            end
         end else if (cnt == CNT_W'(`DBG_BCD_CYCLES)) begin
            busy     <= 1'b0;
            done     <= 1'b1;
            ones     <= sr[`DBG_MEAS_W    +: 4];
            tens     <= sr[`DBG_MEAS_W+4  +: 4];
            hundreds <= sr[`DBG_MEAS_W+8  +: 4];
         end else begin
            cnt <= cnt + 1'b1;
         end
      end
   end

   // Shift register payload
   always_ff @(posedge clk) begin
      if (!busy && sample) begin
         sr <= {12'd0, bin};                               // Digits start at zero
      end else if (busy && cnt != CNT_W'(`DBG_BCD_CYCLES)) begin
         sr <= dd_step(sr);
      end
   end

endmodule

`default_nettype wire

// File: source/seg_pair_encoder.sv
`timescale 1ns/100ps
`default_nettype none

module seg_pair_encoder #(
   parameter bit DEC = 1'b0                 // 1 for BCD digits with overflow mark
) (
   input  logic            clk,
   input  logic            rst_n,
   input  logic            load,
   input  logic [7:0]      value,
   input  logic            ovf,
   output seg_pkg::glyph_t lo,
   output seg_pkg::glyph_t hi
);

   seg_pkg::glyph_t lo_nxt;
   seg_pkg::glyph_t hi_nxt;

   // ------------------------------------------------------------------------
   // Glyph lookup
   // ------------------------------------------------------------------------
   always_comb begin
      lo_nxt = seg_pkg::hex_glyph(value[3:0]);    // Units in decimal mode
      hi_nxt = seg_pkg::hex_glyph(value[7:4]);    // Tens in decimal mode
      if (DEC && ovf) begin
         hi_nxt[7] = 1'b0;                        // Left point marks a value above 99
      end
   end

   // Output pair, dashes until the first load
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         lo <= seg_pkg::GLYPH_DASH;
         hi <= seg_pkg::GLYPH_DASH;
      end else if (load) begin
         lo <= lo_nxt;
         hi <= hi_nxt;
      end
   end

endmodule

`default_nettype wire

// File: source/debug_display.sv
`timescale 1ns/100ps
`default_nettype none

`include "debug_cfg.svh"

module debug_display (
   input  logic                clk,
   input  logic                rst_n,
   input  meas_pkg::view_sel_t sel,
   input  seg_pkg::glyph_t     pair_lo [`DBG_VIEWS],
   input  seg_pkg::glyph_t     pair_hi [`DBG_VIEWS],
   output seg_pkg::glyph_t     seg0,
   output seg_pkg::glyph_t     seg1
);

   seg_pkg::glyph_t lo_nxt;
   seg_pkg::glyph_t hi_nxt;

   // ------------------------------------------------------------------------
   // View select
   // ------------------------------------------------------------------------
   always_comb begin
      lo_nxt = seg_pkg::GLYPH_DASH;               // Zero or multi hot select
      hi_nxt = seg_pkg::GLYPH_DASH;
      case (sel)
         meas_pkg::VIEW_PHI_HEX:   begin lo_nxt = pair_lo[0]; hi_nxt = pair_hi[0]; end
         meas_pkg::VIEW_DELTA_HEX: begin lo_nxt = pair_lo[1]; hi_nxt = pair_hi[1]; end
         meas_pkg::VIEW_VBAT_HEX:  begin lo_nxt = pair_lo[2]; hi_nxt = pair_hi[2]; end
         meas_pkg::VIEW_IBAT_HEX:  begin lo_nxt = pair_lo[3]; hi_nxt = pair_hi[3]; end
         meas_pkg::VIEW_VBAT_DEC:  begin lo_nxt = pair_lo[4]; hi_nxt = pair_hi[4]; end
         meas_pkg::VIEW_IBAT_DEC:  begin lo_nxt = pair_lo[5]; hi_nxt = pair_hi[5]; end
         meas_pkg::VIEW_PHI_DEC:   begin lo_nxt = pair_lo[6]; hi_nxt = pair_hi[6]; end
         meas_pkg::VIEW_DELTA_DEC: begin lo_nxt = pair_lo[7]; hi_nxt = pair_hi[7]; end
         default: ;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         seg0 <= seg_pkg::GLYPH_DASH;
         seg1 <= seg_pkg::GLYPH_DASH;
      end else begin
         seg0 <= lo_nxt;                          // Right digit
         seg1 <= hi_nxt;                          // Left digit
      end
   end

endmodule

`default_nettype wire

// File: source/debug_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "debug_cfg.svh"

module debug_top (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   sample,
   input  logic [`DBG_MEAS_W-1:0] phi,
   input  logic [`DBG_MEAS_W-1:0] delta,
   input  logic [`DBG_MEAS_W-1:0] vbat,
   input  logic [`DBG_MEAS_W-1:0] ibat,
   input  logic [7:0]             sel,
   output logic [7:0]             seg0,
   output logic [7:0]             seg1
);

   logic [3:0][`DBG_MEAS_W-1:0] meas;           // Channel order phi, delta, vbat, ibat
   logic [3:0]                  done;
   logic [3:0][3:0]             ones;
   logic [3:0][3:0]             tens;
   logic [3:0][3:0]             hundreds;
   seg_pkg::glyph_t             pair_lo [`DBG_VIEWS];
   seg_pkg::glyph_t             pair_hi [`DBG_VIEWS];

   assign meas = {ibat, vbat, delta, phi};

   // ------------------------------------------------------------------------
   // Per channel hex and decimal paths
   // ------------------------------------------------------------------------
   for (genvar i = 0; i < 4; i++) begin : g_chan
      // Decimal views run vbat, ibat, phi, delta after the four hex views
      localparam int DEC_VIEW = 4 + ((i + 2) % 4);

      bin_to_bcd i_bin_to_bcd (
         .clk      (clk),
         .rst_n    (rst_n),
         .sample   (sample),
         .bin      (meas[i]),
         .busy     (),
         .done     (done[i]),
         .ones     (ones[i]),
         .tens     (tens[i]),
         .hundreds (hundreds[i])
      );

      seg_pair_encoder #(.DEC(1'b0)) i_hex_enc (
         .clk   (clk),
         .rst_n (rst_n),
         .load  (1'b1),                           // Hex view always live
         .value (meas[i]),
         .ovf   (1'b0),
         .lo    (pair_lo[i]),
         .hi    (pair_hi[i])
      );

      seg_pair_encoder #(.DEC(1'b1)) i_dec_enc (
         .clk   (clk),
         .rst_n (rst_n),
         .load  (done[i]),
         .value ({tens[i], ones[i]}),
         .ovf   (|hundreds[i]),
         .lo    (pair_lo[DEC_VIEW]),
         .hi    (pair_hi[DEC_VIEW])
      );
   end

   debug_display i_debug_display (
      .clk     (clk),
      .rst_n   (rst_n),
      .sel     (sel),
      .pair_lo (pair_lo),
      .pair_hi (pair_hi),
      .seg0    (seg0),
      .seg1    (seg1)
   );

endmodule

`default_nettype wire

// File: sim/debug_top_props.sv
`timescale 1ns/100ps
`default_nettype none

module debug_top_props (
   input logic                clk,
   input logic                rst_n,
   input logic [3:0]          done,
   input meas_pkg::view_sel_t sel,
   input seg_pkg::glyph_t     seg0,
   input seg_pkg::glyph_t     seg1
);

   // -------------------------------------------------------------------------
   // Converter strobes
   // -------------------------------------------------------------------------
   done_single: assert property (@(posedge clk) disable iff (!rst_n)
      (done & $past(done)) == 4'b0000)
      else $error("converter done stayed high for two cycles");

   // -------------------------------------------------------------------------
   // Display output
   // -------------------------------------------------------------------------
   reset_dash: assert property (@(posedge clk)
      $rose(rst_n) |-> (seg0 == seg_pkg::GLYPH_DASH && seg1 == seg_pkg::GLYPH_DASH))
      else $error("display not showing dashes when reset was released");

   // Zero or multi hot select
   invalid_sel_dash: assert property (@(posedge clk) disable iff (!rst_n)
      !$onehot(sel) |=> (seg0 == seg_pkg::GLYPH_DASH && seg1 == seg_pkg::GLYPH_DASH))
      else $error("invalid view select did not give the dash pair");

endmodule

bind debug_top debug_top_props i_debug_top_props (
   .clk   (clk),
   .rst_n (rst_n),
   .done  (done),
   .sel   (sel),
   .seg0  (seg0),
   .seg1  (seg1)
);

`default_nettype wire

// File: sim/debug_top_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "debug_cfg.svh"

module debug_top_tb;

   localparam int NROWS        = 18;
   localparam int DONE_TIMEOUT = 4 * `DBG_BCD_CYCLES;

   logic                clk;
   logic                rst_n;
   logic                sample;
   logic [7:0]          phi;
   logic [7:0]          delta;
   logic [7:0]          vbat;
   logic [7:0]          ibat;
   meas_pkg::view_sel_t sel;
   seg_pkg::glyph_t     seg0;
   seg_pkg::glyph_t     seg1;

   // Stimulus table and expected digits
   logic [7:0]          row_phi   [NROWS];
   logic [7:0]          row_delta [NROWS];
   logic [7:0]          row_vbat  [NROWS];
   logic [7:0]          row_ibat  [NROWS];
   meas_pkg::view_sel_t row_sel   [NROWS];
   seg_pkg::glyph_t     exp_seg0  [NROWS];
   seg_pkg::glyph_t     exp_seg1  [NROWS];

   int n_checks;
   int n_errors;
   int seed;
   bit timed_out;

   debug_top i_debug_top (
      .clk    (clk),
      .rst_n  (rst_n),
      .sample (sample),
      .phi    (phi),
      .delta  (delta),
      .vbat   (vbat),
      .ibat   (ibat),
      .sel    (sel),
      .seg0   (seg0),
      .seg1   (seg1)
   );

   always #20 clk = ~clk;                          // 40 ns period

   // -------------------------------------------------------------------------
   // Reference model of one view, returns {seg1, seg0}
   // -------------------------------------------------------------------------
   function automatic logic [15:0] model_pair(input logic [7:0] p, input logic [7:0] d,
                                              input logic [7:0] v, input logic [7:0] i,
                                              input meas_pkg::view_sel_t s);
      logic [7:0]      val;
      bit              dec;
      seg_pkg::glyph_t lo;
      seg_pkg::glyph_t hi;
      val = 8'h00;
      case (s)
         meas_pkg::VIEW_PHI_HEX:   val = p;
         meas_pkg::VIEW_DELTA_HEX: val = d;
         meas_pkg::VIEW_VBAT_HEX:  val = v;
         meas_pkg::VIEW_IBAT_HEX:  val = i;
         meas_pkg::VIEW_VBAT_DEC:  val = v;
         meas_pkg::VIEW_IBAT_DEC:  val = i;
         meas_pkg::VIEW_PHI_DEC:   val = p;
         meas_pkg::VIEW_DELTA_DEC: val = d;
         default: return {seg_pkg::GLYPH_DASH, seg_pkg::GLYPH_DASH};
      endcase
      dec = |s[7:4];                               // Upper four views are decimal
      if (dec) begin
         lo = seg_pkg::hex_glyph(4'(val % 8'd10));
         hi = seg_pkg::hex_glyph(4'((val / 8'd10) % 8'd10));
         if (val >= 8'd100) begin
            hi[7] = 1'b0;                          // Overflow point, active low
         end
      end else begin
         lo = seg_pkg::hex_glyph(val[3:0]);
         hi = seg_pkg::hex_glyph(val[7:4]);
      end
      return {hi, lo};
   endfunction

   task automatic build_table();
      for (int r = 0; r < NROWS; r++) begin
         row_phi[r]   = 8'($random(seed));
         row_delta[r] = 8'($random(seed));
         row_vbat[r]  = 8'($random(seed));
         row_ibat[r]  = 8'($random(seed));
      end
      row_sel = '{meas_pkg::VIEW_PHI_HEX, meas_pkg::VIEW_DELTA_HEX, meas_pkg::VIEW_VBAT_HEX,
                  meas_pkg::VIEW_IBAT_HEX, meas_pkg::VIEW_VBAT_DEC, meas_pkg::VIEW_IBAT_DEC,
                  meas_pkg::VIEW_PHI_DEC, meas_pkg::VIEW_DELTA_DEC, meas_pkg::VIEW_VBAT_DEC,
                  meas_pkg::VIEW_IBAT_DEC, meas_pkg::VIEW_PHI_DEC, meas_pkg::VIEW_DELTA_DEC,
                  meas_pkg::VIEW_VBAT_DEC, meas_pkg::VIEW_IBAT_DEC,
                  8'h00, 8'h03, 8'hFF, 8'h90};     // Last four are not one hot
      row_vbat[8]   = 8'd0;                        // Decimal corner values
      row_ibat[9]   = 8'd9;
      row_phi[10]   = 8'd99;
      row_delta[11] = 8'd100;
      row_vbat[12]  = 8'd255;
      row_ibat[13]  = 8'd160;
      for (int r = 0; r < NROWS; r++) begin
         {exp_seg1[r], exp_seg0[r]} = model_pair(row_phi[r], row_delta[r], row_vbat[r],
                                                 row_ibat[r], row_sel[r]);
      end
   endtask

   // -------------------------------------------------------------------------
   // Drive, wait and compare
   // -------------------------------------------------------------------------
   task automatic wait_cycles(input int n);
      for (int c = 0; c < n; c++) begin
         @(negedge clk);
      end
   endtask

   task automatic drive_sample(input logic [7:0] p, input logic [7:0] d,
                               input logic [7:0] v, input logic [7:0] i);
      phi    = p;
      delta  = d;
      vbat   = v;
      ibat   = i;
      sample = 1'b1;
      @(negedge clk);
      sample = 1'b0;
   endtask

   task automatic wait_done(output bit ok);
      int cycles;
      ok     = 1'b0;
      cycles = 0;
      while (!ok && cycles < DONE_TIMEOUT) begin
         @(negedge clk);
         cycles++;
         if (&i_debug_top.done) begin
            ok = 1'b1;
         end
      end
      if (!ok) begin
         $display("timeout: converters gave no done pulse within %0d cycles", cycles);
         n_errors++;
         timed_out = 1'b1;
      end
   endtask

   task automatic check_pair(input string what, input seg_pkg::glyph_t exp0,
                             input seg_pkg::glyph_t exp1);
      n_checks++;
      assert (seg0 === exp0) else begin
         $display("error seg0 %s expected %h got %h", what, exp0, seg0);
         n_errors++;
      end
      assert (seg1 === exp1) else begin
         $display("error seg1 %s expected %h got %h", what, exp1, seg1);
         n_errors++;
      end
   endtask

   task automatic apply_row(input int r);
      bit ok;
      drive_sample(row_phi[r], row_delta[r], row_vbat[r], row_ibat[r]);
      wait_done(ok);
      if (ok) begin
         wait_cycles(2);                           // Encoder then display register
         sel = row_sel[r];
         @(negedge clk);
         check_pair($sformatf("row %0d", r), exp_seg0[r], exp_seg1[r]);
      end
   endtask

   // Second sample lands mid conversion and must be dropped
   task automatic check_busy_drop();
      bit          ok;
      logic [15:0] exp;
      exp = model_pair(8'd0, 8'd0, 8'd42, 8'd0, meas_pkg::VIEW_VBAT_DEC);
      drive_sample(8'd0, 8'd0, 8'd42, 8'd0);
      wait_cycles(2);
      drive_sample(8'd0, 8'd0, 8'd177, 8'd0);
      wait_done(ok);
      if (ok) begin
         wait_cycles(2);
         sel = meas_pkg::VIEW_VBAT_DEC;
         @(negedge clk);
         check_pair("busy sample", exp[7:0], exp[15:8]);
         wait_cycles(3 * `DBG_BCD_CYCLES);         // No late conversion may follow
         check_pair("busy sample held", exp[7:0], exp[15:8]);
      end
   endtask

   // -------------------------------------------------------------------------
   // Main sequence
   // -------------------------------------------------------------------------
   initial begin
      clk       = 1'b0;
      rst_n     = 1'b0;
      sample    = 1'b0;
      phi       = 8'h00;
      delta     = 8'h00;
      vbat      = 8'h00;
      ibat      = 8'h00;
      sel       = 8'h00;
      n_checks  = 0;
      n_errors  = 0;
      timed_out = 1'b0;
      seed      = 32'hd819_9575;
      build_table();
      wait_cycles(5);
      rst_n = 1'b1;
      check_pair("after reset", seg_pkg::GLYPH_DASH, seg_pkg::GLYPH_DASH);  // Reset value
      sel = meas_pkg::VIEW_PHI_DEC;                // No conversion has run yet
      @(negedge clk);
      check_pair("decimal view before sample", seg_pkg::GLYPH_DASH, seg_pkg::GLYPH_DASH);
      for (int r = 0; r < NROWS && !timed_out; r++) begin
         apply_row(r);
      end
      if (!timed_out) begin
         check_busy_drop();
      end
      $display("checks %0d errors %0d", n_checks, n_errors);
      if (n_errors == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+source
source/seg_pkg.sv
source/meas_pkg.sv
source/bin_to_bcd.sv
source/seg_pair_encoder.sv
source/debug_display.sv
source/debug_top.sv
sim/debug_top_props.sv
sim/debug_top_tb.sv

// File: Makefile
# Verilator build and run of the debug display testbench

VERILATOR ?= verilator
TOP       ?= debug_top_tb
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= vlog.f
VFLAGS    ?= --binary --timing --assert

BIN  := $(OBJ_DIR)/V$(TOP)
SRCS := $(wildcard source/*.sv source/*.svh sim/*.sv)

.PHONY: all run check clean

all: check

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)

check: run
	@if grep -q "STATUS: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "STATUS: PASS" $(LOG); then echo "simulation did not finish"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
